/* design/sssp_pkg.sv */
package sssp_pkg;

   localparam int WORD_W     = 32;
   localparam int LINE_WORDS = 16;
   localparam int LINE_W     = WORD_W * LINE_WORDS; // 64-byte line

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [31:0]           addr_t; // byte address
   typedef logic [3:0]            word_idx_t;
   typedef logic [LINE_WORDS-1:0] word_mask_t;

   typedef struct packed {
      word_t ts;
      word_t locale;
   } vertex_task_t;

   // one read, never crosses a line
   typedef struct packed {
      addr_t      addr; // line aligned
      logic [4:0] n_words;
   } mem_req_t;

   typedef enum logic {
      OFFSET_READ,
      EDGE_READ
   } req_kind_t;

   typedef struct packed {
      req_kind_t  kind;
      word_idx_t  start;
      logic [4:0] n_words;
      logic       last; // final line of the burst
   } req_tag_t;

   typedef struct packed {
      logic [LINE_W-1:0] data;
      req_tag_t          tag;
   } line_beat_t;

   typedef struct packed {
      word_t lo;
      word_t hi;
   } range_t;

   typedef logic [15:0] child_cnt_t;

   typedef struct packed {
      word_t      locale;
      child_cnt_t cnt;
   } finish_t;

endpackage

/* design/stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH_LOG = 1
) (
   input  logic     clk,
   input  logic     rstn,
   input  logic     push,
   input  payload_t push_data,
   output logic     full,
   input  logic     pop,
   output payload_t pop_data,
   output logic     empty
);

   localparam int DEPTH = 2 ** DEPTH_LOG;

   payload_t             slots [DEPTH];
   logic [DEPTH_LOG-1:0] wr_ptr;
   logic [DEPTH_LOG-1:0] rd_ptr;
   logic [DEPTH_LOG:0]   count;
   logic                 do_push;
   logic                 do_pop;

   assign do_push = push & !full;
   assign do_pop  = pop & !empty;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + do_push - do_pop;
      end
   end

   always_ff @(posedge clk) begin
      if (do_push) slots[wr_ptr] <= push_data;
   end

   assign pop_data = slots[rd_ptr]; // head entry
   assign full     = (count == (DEPTH_LOG + 1)'(DEPTH));
   assign empty    = (count == '0);

endmodule

/* design/edge_request_gen.sv */
`timescale 1ns/1ns

module edge_request_gen (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   task_valid,
   output logic                   task_ready,
   input  sssp_pkg::vertex_task_t task_in,

   input  sssp_pkg::addr_t        offset_base,
   input  sssp_pkg::addr_t        neighbor_base,

   output logic                   ar_valid,
   input  logic                   ar_ready,
   output sssp_pkg::mem_req_t     ar_req,

   output logic                   tag_push,
   output sssp_pkg::req_tag_t     tag,
   input  logic                   tag_ready,

   input  logic                   range_valid,
   input  sssp_pkg::range_t       range,
   input  logic                   task_done,

   output sssp_pkg::vertex_task_t task_in_flight,
   output logic                   idle
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_OFFSET,
      S_WAIT, // range or finish pending
      S_EDGE
   } state_t;

   state_t              state;
   sssp_pkg::addr_t     req_addr;   // byte address of the next word to read
   sssp_pkg::word_t     words_left;
   sssp_pkg::req_kind_t req_kind;
   sssp_pkg::word_idx_t start;
   logic [4:0]          room;
   logic [4:0]          n_words;
   logic                last;
   logic                issuing;
   logic                ar_fire;

   // words from the current position up to the line end
   assign start   = req_addr[5:2];
   assign room    = 5'(sssp_pkg::LINE_WORDS) - {1'b0, start};
   assign last    = (words_left <= sssp_pkg::word_t'(room));
   assign n_words = last ? words_left[4:0] : room;

   assign issuing  = (state == S_OFFSET) || (state == S_EDGE);
   assign ar_valid = issuing & tag_ready; // no request without a tag slot
   assign ar_fire  = ar_valid & ar_ready;

   assign ar_req.addr    = {req_addr[31:6], 6'b0};
   assign ar_req.n_words = n_words;

   assign tag.kind    = req_kind;
   assign tag.start   = start;
   assign tag.n_words = n_words;
   assign tag.last    = last;
   assign tag_push    = ar_fire;

   assign task_ready = (state == S_IDLE);
   assign idle       = (state == S_IDLE);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (task_valid) state <= S_OFFSET;
            end
            S_OFFSET: begin
               if (ar_fire && last) state <= S_WAIT;
            end
            S_WAIT: begin
               // an empty list finishes together with its range
               if (task_done) begin
                  state <= S_IDLE;
               end else if (range_valid) begin
                  state <= S_EDGE;
               end
            end
            S_EDGE: begin
               if (ar_fire && last) state <= S_WAIT;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && task_valid) begin
         task_in_flight <= task_in;
         req_addr       <= offset_base + (task_in.locale << 2);
         words_left     <= 32'd2; // offset[v] and offset[v+1]
         req_kind       <= sssp_pkg::OFFSET_READ;
      end else if (state == S_WAIT && range_valid) begin
         req_addr   <= neighbor_base + (range.lo << 3); // two words per edge
         words_left <= (range.hi - range.lo) << 1;
         req_kind   <= sssp_pkg::EDGE_READ;
      end else if (ar_fire) begin
         req_addr   <= req_addr + {25'b0, n_words, 2'b00};
         words_left <= words_left - sssp_pkg::word_t'(n_words);
      end
   end

endmodule

/* design/line_response_buffer.sv */
`timescale 1ns/1ns

module line_response_buffer #(
   parameter int TAG_DEPTH_LOG = 2
) (
   input  logic                          clk,
   input  logic                          rstn,

   input  logic                          tag_push,
   input  sssp_pkg::req_tag_t            tag,
   output logic                          tag_ready,

   input  logic                          r_valid,
   output logic                          r_ready,
   input  logic [sssp_pkg::LINE_W-1:0]   r_data,

   output logic                          beat_valid,
   input  logic                          beat_ready,
   output sssp_pkg::line_beat_t          beat
);

   logic               tag_full;
   logic               tag_empty;
   logic               r_fire;
   logic               hold_valid;
   sssp_pkg::req_tag_t head_tag;

   // tags of the outstanding reads, oldest at the head
   stream_fifo #(
      .payload_t (sssp_pkg::req_tag_t),
      .DEPTH_LOG (TAG_DEPTH_LOG)
   ) i_tag_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .push      (tag_push),
      .push_data (tag),
      .full      (tag_full),
      .pop       (r_fire),
      .pop_data  (head_tag),
      .empty     (tag_empty)
   );

   assign tag_ready = !tag_full;

   // lines come back in order, so the head tag belongs to the next line
   assign r_ready    = !tag_empty & (!hold_valid | beat_ready);
   assign r_fire     = r_valid & r_ready;
   assign beat_valid = hold_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         hold_valid <= 1'b0;
      end else if (r_fire) begin
         hold_valid <= 1'b1;
      end else if (beat_ready) begin
         hold_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         beat.data <= r_data;
         beat.tag  <= head_tag;
      end
   end

endmodule

/* design/edge_unpacker.sv */
`timescale 1ns/1ns

module edge_unpacker (
   input  logic                   clk,
   input  logic                   rstn,

   input  logic                   beat_valid,
   output logic                   beat_ready,
   input  sssp_pkg::line_beat_t   beat,

   output logic                   range_valid,
   output sssp_pkg::range_t       range,

   output logic                   child_valid,
   input  logic                   child_ready,
   output sssp_pkg::vertex_task_t child,

   output logic                   finish_valid,
   input  logic                   finish_ready,
   output sssp_pkg::finish_t      finish,

   output logic                   task_done,
   input  sssp_pkg::vertex_task_t task_in_flight
);

   sssp_pkg::word_mask_t tag_mask;
   sssp_pkg::word_mask_t mask_q;
   sssp_pkg::word_mask_t cur_mask;
   sssp_pkg::word_mask_t consumed;
   sssp_pkg::word_mask_t next_mask;
   sssp_pkg::word_idx_t  w0_idx;
   sssp_pkg::word_idx_t  w1_idx;
   sssp_pkg::word_t      w0;
   sssp_pkg::word_t      w1;
   sssp_pkg::word_t      pair_lo;
   sssp_pkg::word_t      pair_hi;
   sssp_pkg::word_t      carry_word;
   sssp_pkg::child_cnt_t cnt;
   sssp_pkg::finish_t    fin_rec;
   logic [5:0]           word_end;
   logic                 started;   // mask_q holds the beat's remaining words
   logic                 carry_valid;
   logic                 w1_ok;
   logic                 has_pair;
   logic                 is_edge;
   logic                 beat_done;
   logic                 needs_finish;
   logic                 fin_ok;
   logic                 fin_full;
   logic                 fin_empty;
   logic                 fire;
   logic                 fin_push;

   assign word_end = {2'b00, beat.tag.start} + {1'b0, beat.tag.n_words};

   always_comb begin
      for (int i = 0; i < sssp_pkg::LINE_WORDS; i++) begin
         tag_mask[i] = (6'(i) >= {2'b00, beat.tag.start}) && (6'(i) < word_end);
      end
   end

   assign cur_mask = started ? mask_q : tag_mask;

   // lowest word still to be taken
   always_comb begin
      w0_idx = '0;
      for (int i = sssp_pkg::LINE_WORDS - 1; i >= 0; i--) begin
         if (cur_mask[i]) begin
            w0_idx = sssp_pkg::word_idx_t'(i);
         end
      end
   end

   assign w1_idx = w0_idx + 4'd1;
   assign w1_ok  = (w0_idx != 4'd15) && cur_mask[w1_idx];
   assign w0     = beat.data[sssp_pkg::WORD_W*w0_idx +: sssp_pkg::WORD_W];
   assign w1     = beat.data[sssp_pkg::WORD_W*w1_idx +: sssp_pkg::WORD_W];

   always_comb begin
      consumed         = '0;
      consumed[w0_idx] = 1'b1;
      has_pair         = 1'b1;
      pair_lo          = w0;
      pair_hi          = w1;
      if (carry_valid) begin
         pair_lo = carry_word; // first half came with the previous line
         pair_hi = w0;
      end else if (w1_ok) begin
         consumed[w1_idx] = 1'b1;
      end else begin
         has_pair = 1'b0; // lone word at line end
      end
   end

   assign next_mask = cur_mask & ~consumed;
   assign beat_done = (next_mask == '0);
   assign is_edge   = (beat.tag.kind == sssp_pkg::EDGE_READ);

   assign needs_finish = has_pair & (is_edge ? (beat_done & beat.tag.last) : (pair_lo == pair_hi));
   assign fin_ok       = !needs_finish | !fin_full;
   assign fire = beat_valid & (!has_pair | (is_edge ? (child_ready & fin_ok) : fin_ok));

   assign child_valid  = beat_valid & has_pair & is_edge & fin_ok;
   assign child.ts     = task_in_flight.ts + pair_hi; // hi word is the weight
   assign child.locale = pair_lo;

   assign range_valid = fire & has_pair & !is_edge;
   assign range.lo    = pair_lo;
   assign range.hi    = pair_hi;

   assign beat_ready = fire & beat_done;
   assign fin_push   = fire & needs_finish;
   assign task_done  = fin_push;

   assign fin_rec.locale = task_in_flight.locale;
   assign fin_rec.cnt    = is_edge ? cnt + sssp_pkg::child_cnt_t'(1) : '0;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         started     <= 1'b0;
         carry_valid <= 1'b0;
         cnt         <= '0;
      end else begin
         if (fire) begin
            started     <= !beat_done;
            carry_valid <= !has_pair;
         end
         if (fin_push) begin
            cnt <= '0;
         end else if (fire & has_pair & is_edge) begin
            cnt <= cnt + sssp_pkg::child_cnt_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         mask_q     <= next_mask;
         carry_word <= w0;
      end
   end

   stream_fifo #(
      .payload_t (sssp_pkg::finish_t),
      .DEPTH_LOG (1)
   ) i_fin_fifo (
      .clk       (clk),
      .rstn      (rstn),
      .push      (fin_push),
      .push_data (fin_rec),
      .full      (fin_full),
      .pop       (finish_valid & finish_ready),
      .pop_data  (finish),
      .empty     (fin_empty)
   );

   assign finish_valid = !fin_empty;

endmodule

/* design/sssp_expand_stage.sv */
`timescale 1ns/1ns

module sssp_expand_stage #(
   parameter int TAG_DEPTH_LOG = 2
) (
   input  logic                        clk,
   input  logic                        rstn,

   input  logic                        task_valid,
   output logic                        task_ready,
   input  sssp_pkg::vertex_task_t      task_in,

   input  sssp_pkg::addr_t             offset_base,
   input  sssp_pkg::addr_t             neighbor_base,

   output logic                        ar_valid,
   input  logic                        ar_ready,
   output sssp_pkg::mem_req_t          ar_req,

   input  logic                        r_valid,
   output logic                        r_ready,
   input  logic [sssp_pkg::LINE_W-1:0] r_data,

   output logic                        child_valid,
   input  logic                        child_ready,
   output sssp_pkg::vertex_task_t      child,

   output logic                        finish_valid,
   input  logic                        finish_ready,
   output sssp_pkg::finish_t           finish,

   output logic                        idle
);

   logic                   tag_push;
   logic                   tag_ready;
   sssp_pkg::req_tag_t     tag;
   logic                   beat_valid;
   logic                   beat_ready;
   sssp_pkg::line_beat_t   beat;
   logic                   range_valid;
   sssp_pkg::range_t       range;
   logic                   task_done;
   sssp_pkg::vertex_task_t task_in_flight;

   edge_request_gen i_req (
      .clk            (clk),
      .rstn           (rstn),
      .task_valid     (task_valid),
      .task_ready     (task_ready),
      .task_in        (task_in),
      .offset_base    (offset_base),
      .neighbor_base  (neighbor_base),
      .ar_valid       (ar_valid),
      .ar_ready       (ar_ready),
      .ar_req         (ar_req),
      .tag_push       (tag_push),
      .tag            (tag),
      .tag_ready      (tag_ready),
      .range_valid    (range_valid),
      .range          (range),
      .task_done      (task_done),
      .task_in_flight (task_in_flight),
      .idle           (idle)
   );

   line_response_buffer #(
      .TAG_DEPTH_LOG (TAG_DEPTH_LOG)
   ) i_buf (
      .clk        (clk),
      .rstn       (rstn),
      .tag_push   (tag_push),
      .tag        (tag),
      .tag_ready  (tag_ready),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .r_data     (r_data),
      .beat_valid (beat_valid),
      .beat_ready (beat_ready),
      .beat       (beat)
   );

   edge_unpacker i_unpack (
      .clk            (clk),
      .rstn           (rstn),
      .beat_valid     (beat_valid),
      .beat_ready     (beat_ready),
      .beat           (beat),
      .range_valid    (range_valid),
      .range          (range),
      .child_valid    (child_valid),
      .child_ready    (child_ready),
      .child          (child),
      .finish_valid   (finish_valid),
      .finish_ready   (finish_ready),
      .finish         (finish),
      .task_done      (task_done),
      .task_in_flight (task_in_flight)
   );

endmodule

/* verification/tb_sssp_expand_stage.sv */
`timescale 1ns/1ns

module tb_sssp_expand_stage;

   localparam int N_VERTS        = 24;
   localparam int MAX_DEG        = 12;
   localparam int N_ROUNDS       = 2;
   localparam int MEM_WORDS      = 2048;
   localparam int N_EDGES_MAX    = N_VERTS * MAX_DEG + 8;
   localparam int TIMEOUT_CYCLES = N_ROUNDS * N_VERTS * 400;

   logic                        clk;
   logic                        rstn;
   logic                        task_valid;
   logic                        task_ready;
   sssp_pkg::vertex_task_t      task_in;
   sssp_pkg::addr_t             offset_base;
   sssp_pkg::addr_t             neighbor_base;
   logic                        ar_valid;
   logic                        ar_ready;
   sssp_pkg::mem_req_t          ar_req;
   logic                        r_valid;
   logic                        r_ready;
   logic [sssp_pkg::LINE_W-1:0] r_data;
   logic                        child_valid;
   logic                        child_ready;
   sssp_pkg::vertex_task_t      child;
   logic                        finish_valid;
   logic                        finish_ready;
   sssp_pkg::finish_t           finish;
   logic                        idle;

   logic [31:0]            lfsr;
   sssp_pkg::word_t        mem [MEM_WORDS];
   sssp_pkg::word_t        offs [N_VERTS + 1];
   sssp_pkg::word_t        nbr [N_EDGES_MAX];
   sssp_pkg::word_t        wt [N_EDGES_MAX];
   sssp_pkg::vertex_task_t exp_children [$];
   sssp_pkg::finish_t      exp_fin;
   sssp_pkg::addr_t        line_q [$];   // accepted reads, oldest first
   sssp_pkg::addr_t        next_pos;     // byte address the DUT should read next
   int                     off_left;
   int                     edge_left;
   int                     cur_v;
   int                     errors;
   int                     checks;
   int                     n_tasks;
   int                     n_children;
   int                     n_finish;
   int                     cycle_cnt;
   logic                   in_flight;
   logic                   got_fin;
   logic                   accepted;
   logic                   task_hs;
   logic                   r_hs;
   logic                   idle_s;

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   sssp_expand_stage #(
      .TAG_DEPTH_LOG (2)
   ) i_dut (
      .clk           (clk),
      .rstn          (rstn),
      .task_valid    (task_valid),
      .task_ready    (task_ready),
      .task_in       (task_in),
      .offset_base   (offset_base),
      .neighbor_base (neighbor_base),
      .ar_valid      (ar_valid),
      .ar_ready      (ar_ready),
      .ar_req        (ar_req),
      .r_valid       (r_valid),
      .r_ready       (r_ready),
      .r_data        (r_data),
      .child_valid   (child_valid),
      .child_ready   (child_ready),
      .child         (child),
      .finish_valid  (finish_valid),
      .finish_ready  (finish_ready),
      .finish        (finish),
      .idle          (idle)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r    = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [sssp_pkg::LINE_W-1:0] read_line(input sssp_pkg::addr_t addr);
      logic [sssp_pkg::LINE_W-1:0] data;
      int                          base_w;
      base_w = int'(addr[12:2]);
      for (int k = 0; k < sssp_pkg::LINE_WORDS; k++) begin
         data[k*sssp_pkg::WORD_W +: sssp_pkg::WORD_W] = mem[(base_w + k) % MEM_WORDS];
      end
      return data;
   endfunction

   task automatic note_mismatch(input string name, input logic [63:0] exp_v,
                                input logic [63:0] got_v);
      errors++;
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp_v, got_v);
   endtask

   task automatic raise_error(input string msg);
      errors++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   task automatic build_graph(input bit aligned);
      int deg;
      int ofs_w;
      int nb_w;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f; // background follows the address
      end
      if (aligned) begin
         offset_base   = rand_bits(3) << 6;
         neighbor_base = 32'h400 + (rand_bits(3) << 6);
      end else begin
         offset_base   = rand_bits(7) << 2;
         neighbor_base = 32'h404 + (rand_bits(7) << 3); // odd word start splits some edge pairs
      end
      ofs_w   = int'(offset_base >> 2);
      nb_w    = int'(neighbor_base >> 2);
      offs[0] = rand_bits(3);
      for (int v = 0; v < N_VERTS; v++) begin
         deg = int'(rand_bits(4) % 13);
         if (v == 3) deg = 0;         // empty list
         if (v == 5) deg = MAX_DEG;   // list longer than a line
         offs[v + 1] = offs[v] + 32'(deg);
      end
      for (int v = 0; v <= N_VERTS; v++) begin
         mem[ofs_w + v] = offs[v];
      end
      // each entry is the neighbor id then the weight
      for (int e = int'(offs[0]); e < int'(offs[N_VERTS]); e++) begin
         nbr[e]                = rand_bits(5) % N_VERTS;
         wt[e]                 = rand_bits(16);
         mem[nb_w + 2 * e]     = nbr[e];
         mem[nb_w + 2 * e + 1] = wt[e];
      end
   endtask

   task automatic check_reset_state();
      checks++;
      if (ar_valid !== 1'b0) note_mismatch("ar_valid", 64'd0, 64'(ar_valid));
      if (r_ready !== 1'b0) note_mismatch("r_ready", 64'd0, 64'(r_ready));
      if (child_valid !== 1'b0) note_mismatch("child_valid", 64'd0, 64'(child_valid));
      if (finish_valid !== 1'b0) note_mismatch("finish_valid", 64'd0, 64'(finish_valid));
      if (idle !== 1'b1) note_mismatch("idle", 64'd1, 64'(idle));
      if (task_ready !== 1'b1) note_mismatch("task_ready", 64'd1, 64'(task_ready));
   endtask

   task automatic check_request();
      logic [5:0] span;
      int         n;
      checks++;
      n    = int'(ar_req.n_words);
      span = {2'b00, next_pos[5:2]} + {1'b0, ar_req.n_words};
      if (ar_req.addr != {next_pos[31:6], 6'b0}) begin
         note_mismatch("ar_req.addr", 64'({next_pos[31:6], 6'b0}), 64'(ar_req.addr));
      end
      if (n == 0 || span > 6'd16) begin
         raise_error("read request is empty or runs past the end of its line");
      end
      next_pos = next_pos + (32'(ar_req.n_words) << 2);
      if (off_left > 0) begin
         off_left = off_left - n;
         if (off_left < 0) raise_error("offset read covers more than two words");
         if (off_left == 0) next_pos = neighbor_base + (offs[cur_v] << 3);
      end else begin
         edge_left = edge_left - n;
         if (edge_left < 0) raise_error("edge reads go past the end of the neighbor list");
      end
      line_q.push_back(ar_req.addr);
   endtask

   task automatic check_child();
      sssp_pkg::vertex_task_t exp_c;
      checks++;
      n_children++;
      if (exp_children.size() == 0) begin
         raise_error("child task arrived when none was expected");
      end else begin
         exp_c = exp_children.pop_front();
         if (child.ts != exp_c.ts) note_mismatch("child.ts", 64'(exp_c.ts), 64'(child.ts));
         if (child.locale != exp_c.locale) begin
            note_mismatch("child.locale", 64'(exp_c.locale), 64'(child.locale));
         end
      end
   endtask

   task automatic check_finish();
      int exp_words;
      checks++;
      n_finish++;
      exp_words = 2 * int'(exp_fin.cnt);
      if (!in_flight) begin
         raise_error("finish record arrived with no task in flight");
      end else begin
         if (exp_children.size() != 0) raise_error("finish record came before the last child");
         if (finish.locale != exp_fin.locale) begin
            note_mismatch("finish.locale", 64'(exp_fin.locale), 64'(finish.locale));
         end
         if (finish.cnt != exp_fin.cnt) begin
            note_mismatch("finish.cnt", 64'(exp_fin.cnt), 64'(finish.cnt));
         end
         if (edge_left != 0) begin
            note_mismatch("edge read words", 64'(exp_words), 64'(exp_words - edge_left));
         end
         if (idle !== 1'b1) note_mismatch("idle", 64'd1, 64'(idle));
      end
      got_fin   = 1'b1;
      in_flight = 1'b0;
   endtask

   // memory answers in order, after a random gap
   task automatic drive_channels();
      if (r_hs) begin
         line_q.delete(0);
         r_valid = 1'b0;
      end
      if (!r_valid && line_q.size() != 0 && rand_bits(2) != 0) begin
         r_data  = read_line(line_q[0]);
         r_valid = 1'b1;
      end
      ar_ready     = (rand_bits(2) != 0);
      child_ready  = (rand_bits(2) != 0);
      finish_ready = (rand_bits(1) != 0);
   endtask

   // sample at the falling edge, drive just after the rising edge
   task automatic step();
      @(negedge clk);
      task_hs = task_valid & task_ready;
      r_hs    = r_valid & r_ready;
      idle_s  = idle;
      if (accepted && !ar_valid) begin
         raise_error("no read request on the cycle after task acceptance");
      end
      if (in_flight && task_ready && !finish_valid) begin
         raise_error("task_ready went high before the finish record was posted");
      end
      accepted = task_hs;
      if (ar_valid && ar_ready) check_request();
      if (child_valid && child_ready) check_child();
      if (finish_valid && finish_ready) check_finish();
      if (task_hs) begin
         in_flight = 1'b1;
         n_tasks++;
      end
      @(posedge clk);
      #1;
      drive_channels();
   endtask

   task automatic run_task(input int v);
      sssp_pkg::vertex_task_t ptask;
      sssp_pkg::vertex_task_t c;
      ptask.ts     = rand_bits(32);
      ptask.locale = 32'(v);
      // expected children in list order, then the finish record
      for (int e = int'(offs[v]); e < int'(offs[v + 1]); e++) begin
         c.ts     = ptask.ts + wt[e];
         c.locale = nbr[e];
         exp_children.push_back(c);
      end
      exp_fin.locale = 32'(v);
      exp_fin.cnt    = 16'(offs[v + 1] - offs[v]);
      cur_v          = v;
      next_pos       = offset_base + 32'(v * 4);
      off_left       = 2;
      edge_left      = 2 * int'(offs[v + 1] - offs[v]);
      got_fin        = 1'b0;
      task_in        = ptask;
      task_valid     = 1'b1;
      do step(); while (!task_hs);
      task_valid = 1'b0;
      while (!got_fin) step();
      while (!idle_s) step();
   endtask

   initial begin : watchdog
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout after %0d cycles, a task never finished", cycle_cnt);
      $display("summary: %0d tasks, %0d children, %0d finish records, %0d checks, %0d errors",
               n_tasks, n_children, n_finish, checks, errors);
      $display("Test failed");
      $finish;
   end

   initial begin
      lfsr          = 32'h2007_a363;
      errors        = 0;
      checks        = 0;
      n_tasks       = 0;
      n_children    = 0;
      n_finish      = 0;
      rstn          = 1'b0;
      task_valid    = 1'b0;
      task_in       = '0;
      offset_base   = '0;
      neighbor_base = '0;
      ar_ready      = 1'b0;
      r_valid       = 1'b0;
      r_data        = '0;
      child_ready   = 1'b0;
      finish_ready  = 1'b0;
      in_flight     = 1'b0;
      got_fin       = 1'b0;
      accepted      = 1'b0;
      task_hs       = 1'b0;
      r_hs          = 1'b0;
      idle_s        = 1'b0;
      off_left      = 0;
      edge_left     = 0;
      cur_v         = 0;
      next_pos      = '0;
      repeat (2) @(posedge clk);
      #1;
      rstn = 1'b1;
      @(negedge clk);
      check_reset_state();
      @(posedge clk);
      #1;
      // first round with line-aligned bases, then word-aligned ones
      for (int round = 0; round < N_ROUNDS; round++) begin
         build_graph(round == 0);
         for (int v = 0; v < N_VERTS; v++) begin
            run_task(v);
         end
      end
      repeat (20) step(); // stray outputs show up here
      $display("summary: %0d tasks, %0d children, %0d finish records, %0d checks, %0d errors",
               n_tasks, n_children, n_finish, checks, errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* all.f */
design/sssp_pkg.sv
design/stream_fifo.sv
design/edge_request_gen.sv
design/line_response_buffer.sv
design/edge_unpacker.sv
design/sssp_expand_stage.sv
verification/tb_sssp_expand_stage.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_sssp_expand_stage \
   -f all.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log
